//--- Makefile
# Verilator build and run for the receive data block testbench

TOP = rx_data_tb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir $(OBJ) -o $(TOP)

# The log decides the result, a failing run stops make with an error
run: compile
	./$(OBJ)/$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf $(OBJ) sim.log

//--- logic/rx_consts.svh
`ifndef RX_CONSTS_SVH
`define RX_CONSTS_SVH

// Width of one output word and of one receive DQ FIFO entry
`define RX_WORD_W 16

// Sample counter width
`define RX_CNT_W 5

// FIFO entries per word in one-lane SDR mode
`define RX_MAX_SAMPLES 16

// Slack cycles on top of the per-row budget of a watchdog
`define RX_WDOG_MARGIN 64

`endif

//--- logic/rx_data_top.sv
`timescale 1ns/100ps
`default_nettype none

module rx_data_top import rx_pkg::*;
(
  input  logic       mem_clk,
  input  logic       reset_n,
  input  logic       rx_enable,
  input  logic       start_read,
  input  logic       rd_done,
  input  lane_mode_e lane_mode,
  input  logic       fifo_empty,
  input  logic       fifo_almost_empty,
  input  logic       fifo_almost_full,
  input  rx_word_t   fifo_dout,
  input  logic       rdata_ack,
  input  logic       dqs_timeout,
  output logic       fifo_rd_en,
  output logic       rdata_valid,
  output logic       dqs_err,
  output logic       rd_clk_stretch,
  output rx_word_t   rdata
);

  logic     room;       // Hold slot free, reader may continue
  logic     word_valid;
  rx_word_t word;

  rx_stream_if u_stream ();

  rx_fifo_reader u_rx_fifo_reader (
    .mem_clk           (mem_clk),
    .reset_n           (reset_n),
    .rx_enable         (rx_enable),
    .start_read        (start_read),
    .rd_done           (rd_done),
    .lane_mode         (lane_mode),
    .fifo_empty        (fifo_empty),
    .fifo_almost_empty (fifo_almost_empty),
    .fifo_almost_full  (fifo_almost_full),
    .fifo_dout         (fifo_dout),
    .room              (room),
    .dqs_timeout       (dqs_timeout),
    .fifo_rd_en        (fifo_rd_en),
    .dqs_err           (dqs_err),
    .rd_clk_stretch    (rd_clk_stretch),
    .stream            (u_stream.reader)
  );

  rx_lane_deserializer u_rx_lane_deserializer (
    .mem_clk    (mem_clk),
    .reset_n    (reset_n),
    .lane_mode  (lane_mode),
    .stream     (u_stream.deserializer),
    .word_valid (word_valid),
    .word       (word)
  );

  rx_word_buffer u_rx_word_buffer (
    .mem_clk     (mem_clk),
    .reset_n     (reset_n),
    .rd_done     (rd_done),
    .word_valid  (word_valid),
    .word        (word),
    .rdata_ack   (rdata_ack),
    .rdata       (rdata),
    .rdata_valid (rdata_valid),
    .room        (room)
  );

endmodule

`default_nettype wire

//--- logic/rx_fifo_reader.sv
`timescale 1ns/100ps
`default_nettype none

`include "rx_consts.svh"

module rx_fifo_reader import rx_pkg::*;
(
  input  logic        mem_clk,
  input  logic        reset_n,
  input  logic        rx_enable,
  input  logic        start_read,
  input  logic        rd_done,
  input  lane_mode_e  lane_mode,
  input  logic        fifo_empty,
  input  logic        fifo_almost_empty,
  input  logic        fifo_almost_full,
  input  rx_word_t    fifo_dout,
  input  logic        room,
  input  logic        dqs_timeout,
  output logic        fifo_rd_en,
  output logic        dqs_err,
  output logic        rd_clk_stretch,
  rx_stream_if.reader stream
);

  localparam logic [`RX_CNT_W-1:0] max_samples = `RX_CNT_W'(`RX_MAX_SAMPLES);

  reader_state_e        state;
  reader_state_e        state_nxt;
  logic [`RX_CNT_W-1:0] rd_cnt;     // Reads left before the final one of a word
  logic [`RX_CNT_W-1:0] cnt_load;
  logic                 start_read_d;
  logic                 start_edge;
  logic                 last_rd;    // This read completes a word
  logic                 last_rd_d2;
  logic                 pipe_busy;

  assign start_edge = start_read && !start_read_d;

  // 16, 8, 4 or 2 samples per word, counted down to zero
  assign cnt_load = (max_samples >> lane_mode) - 1'b1;

  // A finished word still on its way to the buffer
  assign pipe_busy = stream.word_last || last_rd_d2;

  // The final read of a word waits until the previous word has left the
  // deserializer, so the hold slot can never be overrun
  assign fifo_rd_en = (state == rd_active) && rx_enable && !fifo_empty && !rd_done &&
                      room && ((rd_cnt != '0) || !pipe_busy);

  assign last_rd = fifo_rd_en && (rd_cnt == '0);

  assign stream.sample = fifo_dout; // FIFO returns data one cycle after the read
  assign stream.flush  = rd_done;

  always_comb
  begin
    state_nxt = state;
    case (state)
      rd_idle:    if (start_edge) state_nxt = rd_active;
      rd_active:  if (!room)      state_nxt = rd_stalled;
      rd_stalled: if (room)       state_nxt = rd_active;
      default:                    state_nxt = rd_idle;
    endcase
    if (rd_done)
      state_nxt = rd_idle; // End of read always wins
  end

  always_ff @(posedge mem_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state               <= rd_idle;
      start_read_d        <= 1'b0;
      rd_cnt              <= '0;
      stream.sample_valid <= 1'b0;
      stream.word_last    <= 1'b0;
      last_rd_d2          <= 1'b0;
    end
    else
    begin
      state               <= state_nxt;
      start_read_d        <= start_read;
      stream.sample_valid <= fifo_rd_en;
      stream.word_last    <= last_rd;
      last_rd_d2          <= stream.word_last && !rd_done;

      if (rd_done)
        rd_cnt <= '0;
      else if (start_edge)
        rd_cnt <= cnt_load;
      else if (fifo_rd_en)
        rd_cnt <= (rd_cnt == '0) ? cnt_load : rd_cnt - 1'b1; // Reload per word
    end
  end

  // DQS non-toggle error pulses every other cycle while the timeout holds
  always_ff @(posedge mem_clk or negedge reset_n)
  begin
    if (!reset_n)
      dqs_err <= 1'b0;
    else
      dqs_err <= dqs_err ? 1'b0 : dqs_timeout;
  end

  // Ask for a slower read clock while the FIFO runs near full
  always_ff @(posedge mem_clk or negedge reset_n)
  begin
    if (!reset_n)
      rd_clk_stretch <= 1'b0;
    else if (rd_done || fifo_empty || fifo_almost_empty)
      rd_clk_stretch <= 1'b0;
    else if (fifo_almost_full)
      rd_clk_stretch <= 1'b1;
  end

  // Lane mode must stay put while a read is in progress
  a_cnt_in_range: assert property (@(posedge mem_clk) disable iff (!reset_n)
    (state != rd_idle) |-> (rd_cnt <= cnt_load));

endmodule

`default_nettype wire

//--- logic/rx_lane_deserializer.sv
`timescale 1ns/100ps
`default_nettype none

`include "rx_consts.svh"

module rx_lane_deserializer import rx_pkg::*;
(
  input  logic              mem_clk,
  input  logic              reset_n,
  input  lane_mode_e        lane_mode,
  rx_stream_if.deserializer stream,
  output logic              word_valid,
  output rx_word_t          word
);

  rx_word_t shift_q;   // Word being assembled, first sample ends up on top
  rx_word_t shift_nxt;
  logic     word_done;

  assign word_done = stream.sample_valid && stream.word_last;

  // Only the upper byte of a FIFO entry carries lane data
  always_comb
  begin
    case (lane_mode)
      lane_x8: shift_nxt = {shift_q[7:0], stream.sample[15:8]};
      lane_x4: shift_nxt = {shift_q[11:0], stream.sample[11:8]};
      lane_x2: shift_nxt = {shift_q[13:0], stream.sample[9:8]};
      default: shift_nxt = {shift_q[14:0], stream.sample[9]}; // Single line on bit 9
    endcase
  end

  always_ff @(posedge mem_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      shift_q    <= '0;
      word_valid <= 1'b0;
    end
    else if (stream.flush)
    begin
      shift_q    <= '0;
      word_valid <= 1'b0;
    end
    else
    begin
      word_valid <= word_done;
      if (stream.sample_valid)
        shift_q <= stream.word_last ? '0 : shift_nxt;
    end
  end

  // Finished word goes out byte-swapped
  always_ff @(posedge mem_clk)
  begin
    if (word_done)
      word <= {shift_nxt[`RX_WORD_W/2-1:0], shift_nxt[`RX_WORD_W-1:`RX_WORD_W/2]};
  end

  a_last_has_valid: assert property (@(posedge mem_clk) disable iff (!reset_n)
    stream.word_last |-> stream.sample_valid);

endmodule

`default_nettype wire

//--- logic/rx_pkg.sv
`default_nettype none

`include "rx_consts.svh"

package rx_pkg;

  // Number of active data lines, SDR only
  typedef enum logic [1:0] {
    lane_x1 = 2'd0,
    lane_x2 = 2'd1,
    lane_x4 = 2'd2,
    lane_x8 = 2'd3
  } lane_mode_e;

  // FIFO reader control
  typedef enum logic [1:0] {
    rd_idle    = 2'd0, // Waiting for start_read
    rd_active  = 2'd1, // Reading whenever the FIFO has data
    rd_stalled = 2'd2  // Output side full, reads held back
  } reader_state_e;

  // One received data word, also one FIFO entry
  typedef logic [`RX_WORD_W-1:0] rx_word_t;

endpackage

`default_nettype wire

//--- logic/rx_stream_if.sv
`timescale 1ns/100ps
`default_nettype none

// Raw FIFO samples from the reader to the lane deserializer
interface rx_stream_if import rx_pkg::*;
();

  rx_word_t sample;       // FIFO entry, data in the upper byte
  logic     sample_valid; // One cycle after a qualified FIFO read
  logic     word_last;    // Sample that completes the current word
  logic     flush;        // Drop any partly assembled word

  modport reader (
    output sample,
    output sample_valid,
    output word_last,
    output flush
  );

  // No back-pressure here, the reader paces itself on room
  modport deserializer (
    input sample,
    input sample_valid,
    input word_last,
    input flush
  );

endinterface

`default_nettype wire

//--- logic/rx_word_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module rx_word_buffer import rx_pkg::*;
(
  input  logic     mem_clk,
  input  logic     reset_n,
  input  logic     rd_done,
  input  logic     word_valid,
  input  rx_word_t word,
  input  logic     rdata_ack,
  output rx_word_t rdata,
  output logic     rdata_valid,
  output logic     room
);

  logic     hold_valid;
  rx_word_t hold_data; // Word parked while rdata waits for its acknowledge
  logic     out_free;

  // Output register empty or handing its word over this cycle
  assign out_free = !rdata_valid || rdata_ack;

  assign room = !hold_valid;

  always_ff @(posedge mem_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      rdata_valid <= 1'b0;
      hold_valid  <= 1'b0;
    end
    else if (rd_done)
    begin
      rdata_valid <= 1'b0;
      hold_valid  <= 1'b0;
    end
    else if (out_free)
    begin
      rdata_valid <= hold_valid || word_valid;
      hold_valid  <= hold_valid && word_valid; // Held word moves up while a new one parks
    end
    else if (word_valid)
    begin
      hold_valid <= 1'b1;
    end
  end

  always_ff @(posedge mem_clk)
  begin
    if (out_free)
    begin
      if (hold_valid)
        rdata <= hold_data; // Older word first
      else if (word_valid)
        rdata <= word;
    end
    if (word_valid && (hold_valid || !out_free))
      hold_data <= word;
  end

  // Reader pacing must keep a third word from arriving
  a_no_overflow: assert property (@(posedge mem_clk) disable iff (!reset_n)
    word_valid |-> !hold_valid || out_free);

endmodule

`default_nettype wire

//--- src.f
+incdir+logic
+incdir+tests
logic/rx_pkg.sv
logic/rx_stream_if.sv
logic/rx_fifo_reader.sv
logic/rx_lane_deserializer.sv
logic/rx_word_buffer.sv
logic/rx_data_top.sv
tests/rx_data_tb.sv

//--- tests/rx_data_tb_checks.svh
`ifndef RX_DATA_TB_CHECKS_SVH
`define RX_DATA_TB_CHECKS_SVH

// Totals for the closing summary line
int check_count = 0;
int error_count = 0;

// Data words on rdata
task automatic check_word(input string name, input rx_word_t got, input rx_word_t exp);
  check_count++;
  if (got !== exp)
  begin
    error_count++;
    $display("** Error at %0t ns: %s is 0x%h, expected 0x%h", $time, name, got, exp);
  end
endtask

// Single-bit status and handshake outputs
task automatic check_flag(input string name, input logic got, input logic exp);
  check_count++;
  if (got !== exp)
  begin
    error_count++;
    $display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
  end
endtask

// Lane mode as seen from the FIFO reads per word
task automatic check_mode(input string name, input lane_mode_e got, input lane_mode_e exp);
  check_count++;
  if (got !== exp)
  begin
    error_count++;
    $display("** Error at %0t ns: %s is %s, expected %s", $time, name,
             got.name(), exp.name());
  end
endtask

`endif

//--- tests/rx_data_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "rx_consts.svh"

module rx_data_tb import rx_pkg::*;
();

  localparam int clk_period  = 40;
  localparam int num_rows    = 10;
  localparam int max_words   = 16;
  localparam int row_cycles  = 400; // Cycle budget of one table row
  localparam int wdog_cycles = 16 + num_rows * row_cycles + `RX_WDOG_MARGIN;

  typedef enum logic [2:0] {ck_stream, ck_empty, ck_abort, ck_dqs, ck_stretch} row_kind_e;

  typedef struct packed {
    lane_mode_e mode;
    int         nwords;
    int         stall;  // Longest random gap in rdata_ack where 0 keeps it high
    row_kind_e  kind;
  } row_t;

  localparam row_t stim_table [num_rows] = '{
    '{lane_x1, 2, 0, ck_stream},
    '{lane_x2, 4, 0, ck_stream},
    '{lane_x4, 6, 0, ck_stream},
    '{lane_x8, 8, 0, ck_stream},
    '{lane_x8, 10, 4, ck_stream},
    '{lane_x2, 3, 3, ck_stream},
    '{lane_x4, 0, 0, ck_empty},
    '{lane_x2, 2, 0, ck_abort},
    '{lane_x8, 0, 0, ck_dqs},
    '{lane_x8, 15, 0, ck_stretch}
  };

  logic       mem_clk;
  logic       reset_n;
  logic       rx_enable;
  logic       start_read;
  logic       rd_done;
  lane_mode_e lane_mode;
  logic       fifo_empty;
  logic       fifo_almost_empty;
  logic       fifo_almost_full;
  rx_word_t   fifo_dout;
  logic       rdata_ack;
  logic       dqs_timeout;
  logic       fifo_rd_en;
  logic       rdata_valid;
  logic       dqs_err;
  logic       rd_clk_stretch;
  rx_word_t   rdata;

  rx_word_t   fifo_q [$];      // FIFO model contents
  int         pop_count;
  logic       empty_read_seen;
  logic       stretch_cleared; // Stretch dropped while the FIFO still held data
  rx_word_t   row_words [num_rows][max_words];

  `include "rx_data_tb_checks.svh"

  always #(clk_period / 2) mem_clk = ~mem_clk;

  rx_data_top u_rx_data_top (
    .mem_clk           (mem_clk),
    .reset_n           (reset_n),
    .rx_enable         (rx_enable),
    .start_read        (start_read),
    .rd_done           (rd_done),
    .lane_mode         (lane_mode),
    .fifo_empty        (fifo_empty),
    .fifo_almost_empty (fifo_almost_empty),
    .fifo_almost_full  (fifo_almost_full),
    .fifo_dout         (fifo_dout),
    .rdata_ack         (rdata_ack),
    .dqs_timeout       (dqs_timeout),
    .fifo_rd_en        (fifo_rd_en),
    .rdata_valid       (rdata_valid),
    .dqs_err           (dqs_err),
    .rd_clk_stretch    (rd_clk_stretch),
    .rdata             (rdata)
  );

  // Receive DQ FIFO model that returns data one cycle after the read
  initial
  begin
    logic pop;
    fifo_dout         = '0;
    fifo_empty        = 1'b1;
    fifo_almost_empty = 1'b1;
    fifo_almost_full  = 1'b0;
    pop_count         = 0;
    empty_read_seen   = 1'b0;
    forever
    begin
      @(negedge mem_clk);
      pop = fifo_rd_en;
      @(posedge mem_clk);
      #2;
      if (pop && fifo_q.size() == 0)
        empty_read_seen = 1'b1;
      else if (pop)
      begin
        fifo_dout = fifo_q.pop_front();
        pop_count++;
      end
      fifo_empty        = (fifo_q.size() == 0);
      fifo_almost_empty = (fifo_q.size() <= 4);
      fifo_almost_full  = (fifo_q.size() >= 28);
    end
  end

  function automatic int samples_per_word(lane_mode_e mode);
    case (mode)
      lane_x8: return 2;
      lane_x4: return 4;
      lane_x2: return 8;
      default: return 16;
    endcase
  endfunction

  function automatic lane_mode_e mode_from_reads(int reads);
    case (reads)
      2:       return lane_x8;
      4:       return lane_x4;
      8:       return lane_x2;
      default: return lane_x1;
    endcase
  endfunction

  task automatic next_cycle();
    @(posedge mem_clk);
    #2;
  endtask

  // FIFO entries for one output word with the first sample on the top bits
  task automatic push_word(input lane_mode_e mode, input rx_word_t word, input int count);
    rx_word_t assembled;
    rx_word_t entry;
    int       bits;
    int       pos;
    assembled = {word[7:0], word[15:8]}; // Undo the output byte swap
    bits = 16 / samples_per_word(mode);
    for (int i = 0; i < count; i++)
    begin
      entry = rx_word_t'($urandom); // Unused lanes carry junk
      for (int k = 0; k < bits; k++)
      begin
        pos = (mode == lane_x1) ? 9 : 7 + bits - k;
        entry[pos] = assembled[15 - i * bits - k];
      end
      fifo_q.push_back(entry);
    end
  endtask

  task automatic pulse_start();
    next_cycle();
    start_read = 1'b1;
    next_cycle();
    start_read = 1'b0;
  endtask

  task automatic end_read();
    next_cycle();
    rd_done   = 1'b1;
    rx_enable = 1'b0;
    next_cycle();
    rd_done   = 1'b0;
  endtask

  task automatic run_stream(input int r);
    lane_mode_e mode;
    int         got;
    int         cycles;
    int         reads_before;
    logic       prev_valid;
    logic       prev_ack;
    rx_word_t   prev_data;
    mode = stim_table[r].mode;
    @(negedge mem_clk);
    reads_before = pop_count;
    for (int w = 0; w < stim_table[r].nwords; w++)
      push_word(mode, row_words[r][w], samples_per_word(mode));
    if (stim_table[r].kind == ck_stretch)
    begin
      repeat (3) next_cycle();
      @(negedge mem_clk);
      check_flag("rd_clk_stretch", rd_clk_stretch, 1'b1); // Almost full with no reads yet
    end
    next_cycle();
    lane_mode = mode;
    rx_enable = 1'b1;
    rdata_ack = 1'b1;
    pulse_start();
    got             = 0;
    cycles          = 0;
    prev_valid      = 1'b0;
    prev_ack        = 1'b1;
    prev_data       = '0;
    stretch_cleared = 1'b0;
    while (got < stim_table[r].nwords && cycles < row_cycles)
    begin
      next_cycle();
      rdata_ack = (stim_table[r].stall == 0) || (($urandom % (stim_table[r].stall + 1)) == 0);
      @(negedge mem_clk);
      if (prev_valid && !prev_ack)
      begin
        check_flag("rdata_valid", rdata_valid, 1'b1); // Held until acknowledged
        check_word("rdata", rdata, prev_data);
      end
      if (!fifo_empty && !rd_clk_stretch)
        stretch_cleared = 1'b1;
      if (rdata_valid && rdata_ack)
      begin
        check_word("rdata", rdata, row_words[r][got]);
        got++;
      end
      prev_valid = rdata_valid;
      prev_ack   = rdata_ack;
      prev_data  = rdata;
      cycles++;
    end
    if (got < stim_table[r].nwords)
    begin
      error_count++;
      $display("Timeout at %0t ns: only %0d of %0d words arrived on rdata", $time, got,
               stim_table[r].nwords);
    end
    repeat (6)
    begin
      next_cycle();
      rdata_ack = 1'b1;
      @(negedge mem_clk);
      check_flag("rdata_valid", rdata_valid, 1'b0); // No extra word
    end
    if (pop_count - reads_before != stim_table[r].nwords * samples_per_word(mode))
    begin
      error_count++;
      $display("FIFO was read %0d times for %0d words", pop_count - reads_before,
               stim_table[r].nwords);
    end
    if (stim_table[r].nwords > 0)
      check_mode("lane mode from reads per word",
                 mode_from_reads((pop_count - reads_before) / stim_table[r].nwords), mode);
    if (stim_table[r].kind == ck_stretch)
      check_flag("rd_clk_stretch cleared before empty", stretch_cleared, 1'b1);
  endtask

  task automatic run_empty(input int r);
    next_cycle();
    lane_mode = stim_table[r].mode;
    rx_enable = 1'b1;
    rdata_ack = 1'b1;
    pulse_start();
    repeat (20)
    begin
      @(negedge mem_clk);
      check_flag("fifo_rd_en", fifo_rd_en, 1'b0);
      check_flag("rdata_valid", rdata_valid, 1'b0);
    end
  endtask

  // One full word left unacknowledged and a second one cut off by rd_done
  task automatic run_abort(input int r);
    lane_mode_e mode;
    rx_word_t   first;
    int         cycles;
    mode  = stim_table[r].mode;
    first = rx_word_t'($urandom);
    @(negedge mem_clk);
    push_word(mode, first, samples_per_word(mode));
    push_word(mode, rx_word_t'($urandom), samples_per_word(mode) / 2);
    next_cycle();
    lane_mode = mode;
    rx_enable = 1'b1;
    rdata_ack = 1'b0;
    pulse_start();
    cycles = 0;
    do
    begin
      @(negedge mem_clk);
      cycles++;
    end
    while (!(fifo_empty && rdata_valid) && cycles < row_cycles);
    repeat (3) next_cycle(); // Last partial sample reaches the deserializer
    @(negedge mem_clk);
    check_flag("rdata_valid", rdata_valid, 1'b1);
    check_word("rdata", rdata, first);
    end_read();
    @(negedge mem_clk);
    check_flag("rdata_valid", rdata_valid, 1'b0);
  endtask

  task automatic run_dqs();
    logic [9:0] exp_err; // Expected dqs_err per cycle with the timeout held in cycles 0 to 5
    exp_err = 10'b00_0010_1010;
    for (int c = 0; c < 10; c++)
    begin
      next_cycle();
      dqs_timeout = (c < 6);
      @(negedge mem_clk);
      check_flag("dqs_err", dqs_err, exp_err[c]);
    end
  endtask

  initial
  begin
    int        errs_before;
    row_kind_e kind;
    void'($urandom(40));
    mem_clk     = 1'b0;
    reset_n     = 1'b0;
    rx_enable   = 1'b0;
    start_read  = 1'b0;
    rd_done     = 1'b0;
    lane_mode   = lane_x1;
    rdata_ack   = 1'b1;
    dqs_timeout = 1'b0;
    for (int r = 0; r < num_rows; r++)
      for (int w = 0; w < max_words; w++)
        row_words[r][w] = rx_word_t'($urandom);
    repeat (16) @(posedge mem_clk);
    #2;
    reset_n = 1'b1;
    @(negedge mem_clk);
    check_flag("fifo_rd_en", fifo_rd_en, 1'b0);
    check_flag("rdata_valid", rdata_valid, 1'b0);
    check_flag("dqs_err", dqs_err, 1'b0);
    check_flag("rd_clk_stretch", rd_clk_stretch, 1'b0);

    for (int r = 0; r < num_rows; r++)
    begin
      errs_before = error_count;
      kind        = stim_table[r].kind;
      case (kind)
        ck_empty: run_empty(r);
        ck_dqs:   run_dqs();
        ck_abort:
        begin
          run_abort(r);
          run_stream(r); // Fresh start_read after the abort
        end
        default:  run_stream(r);
      endcase
      end_read();
      if (error_count == errs_before)
        $display("Row %0d %s %s: ok", r, kind.name(), stim_table[r].mode.name());
      else
        $display("Row %0d %s %s: %0d errors", r, kind.name(), stim_table[r].mode.name(),
                 error_count - errs_before);
    end

    if (empty_read_seen)
    begin
      error_count++;
      $display("FIFO was read while it was empty");
    end
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Hard limit on the run time
  initial
  begin
    #(wdog_cycles * clk_period);
    $display("Watchdog expired after %0d cycles without the run ending", wdog_cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
